// File: hdl/conv_ddr_addr_gen.sv
`timescale 1ns/1ps

module conv_ddr_addr_gen
(
  input  conv_load_pkg::layer_cfg_t cfg,
  input  conv_load_pkg::tile_pos_t  pos,
  input  conv_load_pkg::word_idx_t  word,
  output conv_load_pkg::ddr_req_t   req
);
  import conv_load_pkg::*;

  logic [DIM_W-1:0]   ix_start;
  logic [DIM_W-1:0]   iy_start;
  logic [DIM_W-1:0]   row_raw;
  logic [DIM_W-1:0]   row_idx;
  logic [DIM_W-1:0]   row_start;
  logic [4:0]         row_shift;
  logic [DIM_W-1:0]   row_off;
  logic [2*DIM_W-1:0] col_wide;
  logic [DIM_W-1:0]   col_off;
  logic               pad;

  // first input pixel and row covered by the output tile
  assign ix_start = DIM_W'((pos.tile_x_start - DIM_W'(1)) * DIM_W'(cfg.s)) + DIM_W'(1);
  assign iy_start = DIM_W'((pos.tile_y_start - DIM_W'(1)) * DIM_W'(cfg.s)) + DIM_W'(1);

  // row in padded coordinates, then shifted back by p into image rows
  assign row_raw   = iy_start + DIM_W'(word.chunk_iy) - DIM_W'(1);
  assign row_idx   = row_raw - DIM_W'(cfg.p);
  assign row_start = (DIM_W'(word.chunk_ix - CNT_W'(1)) << PIXELS_IN_ROW_LOG2) + ix_start;

  // rows above or below the image are padding
  assign pad = (row_raw <= DIM_W'(cfg.p)) || (row_idx > cfg.iy);

  ////////////////////
  // word address
  ////////////////////

  // one image row takes ix*nif/64 ddr words
  assign row_shift = {1'b0, cfg.nif_log2} + {1'b0, cfg.ix_log2}
                     - 5'(IFS_IN_WORD_LOG2 + PIXELS_IN_ROW_LOG2);
  assign row_off   = (row_idx - DIM_W'(1)) << row_shift;

  // column offset goes through a wide product before the divide by 64
  assign col_wide = {{DIM_W{1'b0}}, row_start - DIM_W'(1)} << cfg.nif_log2;
  assign col_off  = DIM_W'(col_wide >> (IFS_IN_WORD_LOG2 + PIXELS_IN_ROW_LOG2));

  assign req.adr     = pad ? cfg.base_adr
                           : cfg.base_adr + row_off + col_off
                             + ((word.if_idx - DIM_W'(1)) >> IFS_IN_WORD_LOG2);
  assign req.row_idx = row_idx;
  assign req.if_idx  = word.if_idx;
  assign req.pad     = pad;

endmodule

// File: hdl/conv_load_input_ctrl.sv
`timescale 1ns/1ps

module conv_load_input_ctrl
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 conv_load_input,
  input  logic                                 req_ready,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [conv_load_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [conv_load_pkg::APB_DATA_W-1:0] pwdata,
  output logic [conv_load_pkg::APB_DATA_W-1:0] prdata,
  output logic                                 pready,
  output logic                                 req_valid,
  output conv_load_pkg::ddr_req_t              req,
  output logic                                 chunk_done
);
  import conv_load_pkg::*;

  layer_cfg_t  cfg;
  tile_pos_t   pos;
  chunk_size_t size;
  word_idx_t   word;
  logic        f_wrap;
  logic        tile_step;

  // layer configuration
  conv_load_regs regs_i (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .cfg
  );

  // channel and spatial tile loops
  conv_tile_sequencer seq_i (
    .clk, .reset, .cfg, .conv_load_input, .tile_step,
    .pos, .size, .f_wrap
  );

  // request handshake and word order inside a tile
  conv_word_counter cnt_i (
    .clk, .reset, .cfg, .size, .f_wrap, .conv_load_input, .req_ready,
    .req_valid, .word, .tile_step, .chunk_done
  );

  conv_ddr_addr_gen adr_i (
    .cfg, .pos, .word, .req
  );

endmodule

// File: hdl/conv_load_pkg.sv
package conv_load_pkg;

  ////////////////////
  // tile geometry
  ////////////////////

  // one row word group is 32 output pixels wide
  localparam int PIXELS_IN_ROW      = 32;
  localparam int PIXELS_IN_ROW_LOG2 = 5;
  // output rows per tile, one per row buffer
  localparam int BUFFERS_NUM        = 3;
  // two input channels share one ddr word
  localparam int IFS_IN_WORD_LOG2   = 1;
  // output channels per compute term, 8 bit mode and 1 bit mode
  localparam int ROW_NUM_MODE0      = 64;
  localparam int ROW_NUM_MODE1      = 128;

  localparam int DIM_W = 16;
  localparam int CNT_W = 8;

  ////////////////////
  // apb register map
  ////////////////////

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // of [15:0], nif [31:16]
  localparam logic [APB_ADDR_W-1:0] REG_DIMS        = 8'h00;
  // ox [15:0], oy [31:16]
  localparam logic [APB_ADDR_W-1:0] REG_OUT         = 8'h04;
  // ix [15:0], iy [31:16]
  localparam logic [APB_ADDR_W-1:0] REG_IN          = 8'h08;
  // s [3:0], p [7:4], mode [8], nif_log2 [19:16], ix_log2 [23:20]
  localparam logic [APB_ADDR_W-1:0] REG_SHAPE       = 8'h0c;
  localparam logic [APB_ADDR_W-1:0] REG_BASE        = 8'h10;
  // the table registers hold one byte per class, first in [7:0], mid, then last in [23:16]
  localparam logic [APB_ADDR_W-1:0] REG_IX_WORDS    = 8'h14;
  localparam logic [APB_ADDR_W-1:0] REG_IY_ROWS     = 8'h18;
  localparam logic [APB_ADDR_W-1:0] REG_SPLIT_FIRST = 8'h1c;
  localparam logic [APB_ADDR_W-1:0] REG_SPLIT_MID   = 8'h20;
  localparam logic [APB_ADDR_W-1:0] REG_SPLIT_LAST  = 8'h24;

  ////////////////////
  // types
  ////////////////////

  // position of a tile along x or y, the value doubles as table index
  typedef enum logic [1:0] {
    CLASS_FIRST = 2'd0,
    CLASS_MID   = 2'd1,
    CLASS_LAST  = 2'd2
  } pos_class_t;

  typedef struct packed {
    logic [DIM_W-1:0]           of;
    logic [DIM_W-1:0]           nif;
    logic [DIM_W-1:0]           ox;
    logic [DIM_W-1:0]           oy;
    logic [DIM_W-1:0]           ix;
    logic [DIM_W-1:0]           iy;
    logic [3:0]                 s;
    logic [3:0]                 p;
    logic                       mode;
    logic [3:0]                 nif_log2;
    logic [3:0]                 ix_log2;
    logic [DIM_W-1:0]           base_adr;
    // indexed by x class
    logic [2:0][CNT_W-1:0]      ix_words;
    // indexed by y class
    logic [2:0][CNT_W-1:0]      iy_rows;
    // split [y class][x class]
    logic [2:0][2:0][CNT_W-1:0] split;
  } layer_cfg_t;

  typedef struct packed {
    logic [DIM_W-1:0] tile_x_start;
    logic [DIM_W-1:0] tile_y_start;
    logic [DIM_W-1:0] tile_f_start;
  } tile_pos_t;

  typedef struct packed {
    logic [CNT_W-1:0] ix_size;
    logic [CNT_W-1:0] iy_size;
    logic [CNT_W-1:0] split_size;
  } chunk_size_t;

  typedef struct packed {
    logic [DIM_W-1:0] if_idx;
    logic [CNT_W-1:0] chunk_ix;
    logic [CNT_W-1:0] chunk_iy;
  } word_idx_t;

  typedef struct packed {
    logic [DIM_W-1:0] adr;
    logic [DIM_W-1:0] row_idx;
    logic [DIM_W-1:0] if_idx;
    logic             pad;
  } ddr_req_t;

endpackage

// File: hdl/conv_load_regs.sv
`timescale 1ns/1ps

module conv_load_regs
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 psel,
  input  logic                                 penable,
  input  logic                                 pwrite,
  input  logic [conv_load_pkg::APB_ADDR_W-1:0] paddr,
  input  logic [conv_load_pkg::APB_DATA_W-1:0] pwdata,
  output logic [conv_load_pkg::APB_DATA_W-1:0] prdata,
  output logic                                 pready,
  output conv_load_pkg::layer_cfg_t            cfg
);
  import conv_load_pkg::*;

  logic wr_en;

  // no wait states, writes land on the access phase edge
  assign pready = 1'b1;
  assign wr_en  = psel && penable && pwrite;

  ////////////////////
  // register writes
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      cfg <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        REG_DIMS:
        begin
          cfg.of  <= pwdata[15:0];
          cfg.nif <= pwdata[31:16];
        end
        REG_OUT:
        begin
          cfg.ox <= pwdata[15:0];
          cfg.oy <= pwdata[31:16];
        end
        REG_IN:
        begin
          cfg.ix <= pwdata[15:0];
          cfg.iy <= pwdata[31:16];
        end
        REG_SHAPE:
        begin
          cfg.s        <= pwdata[3:0];
          cfg.p        <= pwdata[7:4];
          cfg.mode     <= pwdata[8];
          cfg.nif_log2 <= pwdata[19:16];
          cfg.ix_log2  <= pwdata[23:20];
        end
        REG_BASE:        cfg.base_adr           <= pwdata[DIM_W-1:0];
        REG_IX_WORDS:    cfg.ix_words           <= pwdata[3*CNT_W-1:0];
        REG_IY_ROWS:     cfg.iy_rows            <= pwdata[3*CNT_W-1:0];
        // one row of the split table per y class
        REG_SPLIT_FIRST: cfg.split[CLASS_FIRST] <= pwdata[3*CNT_W-1:0];
        REG_SPLIT_MID:   cfg.split[CLASS_MID]   <= pwdata[3*CNT_W-1:0];
        REG_SPLIT_LAST:  cfg.split[CLASS_LAST]  <= pwdata[3*CNT_W-1:0];
        default:         cfg                    <= cfg;
      endcase
    end
  end

  ////////////////////
  // read back
  ////////////////////

  // unmapped offsets read as zero
  always_comb
  begin
    prdata = '0;
    case (paddr)
      REG_DIMS:        prdata = {cfg.nif, cfg.of};
      REG_OUT:         prdata = {cfg.oy, cfg.ox};
      REG_IN:          prdata = {cfg.iy, cfg.ix};
      REG_SHAPE:
      begin
        prdata[3:0]   = cfg.s;
        prdata[7:4]   = cfg.p;
        prdata[8]     = cfg.mode;
        prdata[19:16] = cfg.nif_log2;
        prdata[23:20] = cfg.ix_log2;
      end
      REG_BASE:        prdata[DIM_W-1:0]   = cfg.base_adr;
      REG_IX_WORDS:    prdata[3*CNT_W-1:0] = cfg.ix_words;
      REG_IY_ROWS:     prdata[3*CNT_W-1:0] = cfg.iy_rows;
      REG_SPLIT_FIRST: prdata[3*CNT_W-1:0] = cfg.split[CLASS_FIRST];
      REG_SPLIT_MID:   prdata[3*CNT_W-1:0] = cfg.split[CLASS_MID];
      REG_SPLIT_LAST:  prdata[3*CNT_W-1:0] = cfg.split[CLASS_LAST];
      default:         prdata = '0;
    endcase
  end

endmodule

// File: hdl/conv_tile_sequencer.sv
`timescale 1ns/1ps

module conv_tile_sequencer
(
  input  logic                       clk,
  input  logic                       reset,
  input  conv_load_pkg::layer_cfg_t  cfg,
  input  logic                       conv_load_input,
  input  logic                       tile_step,
  output conv_load_pkg::tile_pos_t   pos,
  output conv_load_pkg::chunk_size_t size,
  output logic                       f_wrap
);
  import conv_load_pkg::*;

  logic [DIM_W-1:0] row_num;
  logic             x_wrap;
  logic             y_wrap;
  pos_class_t       x_class;
  pos_class_t       y_class;

  // output channels consumed per compute term
  assign row_num = cfg.mode ? DIM_W'(ROW_NUM_MODE1) : DIM_W'(ROW_NUM_MODE0);

  // wrap checks, one bit wider so the sums cannot overflow
  assign f_wrap = ({1'b0, pos.tile_f_start} + {1'b0, row_num}) > {1'b0, cfg.of};
  assign x_wrap = ({1'b0, pos.tile_x_start} + (DIM_W+1)'(PIXELS_IN_ROW)) > {1'b0, cfg.ox};
  assign y_wrap = ({1'b0, pos.tile_y_start} + (DIM_W+1)'(BUFFERS_NUM)) > {1'b0, cfg.oy};

  ////////////////////
  // loops
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pos.tile_f_start <= DIM_W'(1);
      pos.tile_x_start <= DIM_W'(1);
      pos.tile_y_start <= DIM_W'(1);
    end
    else
    begin
      // inner loop, one channel group per compute term
      if (conv_load_input)
      begin
        pos.tile_f_start <= f_wrap ? DIM_W'(1) : pos.tile_f_start + row_num;
      end
      // spatial loops advance only once a tile is fully loaded
      if (tile_step)
      begin
        pos.tile_x_start <= x_wrap ? DIM_W'(1) : pos.tile_x_start + DIM_W'(PIXELS_IN_ROW);
        if (x_wrap)
        begin
          pos.tile_y_start <= y_wrap ? DIM_W'(1) : pos.tile_y_start + DIM_W'(BUFFERS_NUM);
        end
      end
    end
  end

  ////////////////////
  // chunk size lookup
  ////////////////////

  // first wins over last when a single tile spans the whole axis
  always_comb
  begin
    if (pos.tile_x_start == DIM_W'(1))
      x_class = CLASS_FIRST;
    else if (({1'b0, pos.tile_x_start} + (DIM_W+1)'(PIXELS_IN_ROW - 1)) > {1'b0, cfg.ox})
      x_class = CLASS_LAST;
    else
      x_class = CLASS_MID;

    if (pos.tile_y_start == DIM_W'(1))
      y_class = CLASS_FIRST;
    else if (({1'b0, pos.tile_y_start} + (DIM_W+1)'(BUFFERS_NUM - 1)) > {1'b0, cfg.oy})
      y_class = CLASS_LAST;
    else
      y_class = CLASS_MID;
  end

  assign size.ix_size    = cfg.ix_words[x_class];
  assign size.iy_size    = cfg.iy_rows[y_class];
  assign size.split_size = cfg.split[y_class][x_class];

endmodule

// File: hdl/conv_word_counter.sv
`timescale 1ns/1ps

module conv_word_counter
(
  input  logic                       clk,
  input  logic                       reset,
  input  conv_load_pkg::layer_cfg_t  cfg,
  input  conv_load_pkg::chunk_size_t size,
  input  logic                       f_wrap,
  input  logic                       conv_load_input,
  input  logic                       req_ready,
  output logic                       req_valid,
  output conv_load_pkg::word_idx_t   word,
  output logic                       tile_step,
  output logic                       chunk_done
);
  import conv_load_pkg::*;

  logic             accept;
  logic             if_wrap;
  logic             word_done;
  logic             ix_last;
  logic             iy_last;
  logic             tile_end;
  logic             burst_end;
  logic             burst_start;
  logic             tile_loaded;
  // words completed so far in the current burst, counted from 1
  logic [CNT_W-1:0] burst_words;

  assign accept  = req_valid && req_ready;
  // last channel pair of the current chunk position
  assign if_wrap = ({1'b0, word.if_idx} + (DIM_W+1)'(2)) > {1'b0, cfg.nif};
  assign ix_last = word.chunk_ix == size.ix_size;
  assign iy_last = word.chunk_iy == size.iy_size;

  // a word is one chunk position with all its input channels
  assign word_done = accept && if_wrap;
  assign tile_end  = word_done && ix_last && iy_last;
  assign burst_end = word_done && ((burst_words == size.split_size) || (ix_last && iy_last));

  // reload the tile when the channel loop wraps, it moves on to the next tile
  assign burst_start = conv_load_input && (!tile_loaded || f_wrap);

  ////////////////////
  // burst control
  ////////////////////

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      req_valid  <= 1'b0;
      chunk_done <= 1'b0;
      tile_step  <= 1'b0;
    end
    else
    begin
      if (burst_end)
        req_valid <= 1'b0;
      else if (burst_start)
        req_valid <= 1'b1;
      // both pulses land in the first idle cycle after the burst
      chunk_done <= burst_end;
      tile_step  <= tile_end;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      tile_loaded <= 1'b0;
    else if (tile_end)
      tile_loaded <= 1'b1;
    else if (conv_load_input && f_wrap)
      tile_loaded <= 1'b0;
  end

  ////////////////////
  // word counters
  ////////////////////

  // channel pair fastest, then column chunk, then input row
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      word.if_idx   <= DIM_W'(1);
      word.chunk_ix <= CNT_W'(1);
      word.chunk_iy <= CNT_W'(1);
    end
    else if (accept)
    begin
      word.if_idx <= if_wrap ? DIM_W'(1) : word.if_idx + DIM_W'(2);
      if (if_wrap)
      begin
        word.chunk_ix <= ix_last ? CNT_W'(1) : word.chunk_ix + CNT_W'(1);
        if (ix_last)
        begin
          word.chunk_iy <= iy_last ? CNT_W'(1) : word.chunk_iy + CNT_W'(1);
        end
      end
    end
  end

  // restarts with every burst, the tile position counters run on
  always_ff @(posedge clk)
  begin
    if (reset)
      burst_words <= CNT_W'(1);
    else if (burst_end)
      burst_words <= CNT_W'(1);
    else if (word_done)
      burst_words <= burst_words + CNT_W'(1);
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the load controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -j 0 --top-module tb_conv_load -f verilog.f -o tb_conv_load
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_conv_load > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF '** FAIL **' "$LOG"; then
  echo "simulation failed"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation ended with status $run_status"
  exit 1
fi
echo "simulation passed"
exit 0

// File: verif/tb_conv_load.sv
`timescale 1ns/1ps

module tb_conv_load;
  import conv_load_pkg::*;

  ////////////////////
  // layer under test
  ////////////////////

  // two x tiles (first, last) and two y tiles (first, last)
  localparam int L_OF       = 128;
  localparam int L_NIF      = 4;
  localparam int L_OX       = 60;
  localparam int L_OY       = 5;
  localparam int L_IX       = 64;
  localparam int L_IY       = 4;
  localparam int L_S        = 1;
  localparam int L_P        = 1;
  localparam int L_NIF_LOG2 = 2;
  localparam int L_IX_LOG2  = 6;
  localparam int L_BASE     = 'h100;
  localparam int TILES      = 4;

  // 21 chunk positions of two channel pairs per layer plus one burst of 3 words
  localparam int CLK_NS      = 40;
  localparam int LAYER_REQS  = 42;
  localparam int TEST_REQS   = 2 * LAYER_REQS + 6;
  localparam int WATCHDOG_NS = TEST_REQS * 4 * CLK_NS + 40000;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // chunk widths and heights by class
  // split table by y class then x class
  int ix_words_tab [3]    = '{2, 2, 1};
  int iy_rows_tab  [3]    = '{4, 3, 3};
  int split_tab    [3][3] = '{'{3, 4, 3}, '{4, 4, 4}, '{5, 2, 1}};

  logic                  clk;
  logic                  reset;
  logic                  conv_load_input;
  logic                  req_ready;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_ADDR_W-1:0] paddr;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  req_valid;
  ddr_req_t              req;
  logic                  chunk_done;

  // expected requests of the current pulse and the accepted ones
  ddr_req_t exp_q [$];
  ddr_req_t got_q [$];

  // reference model state
  int   m_f;
  int   m_x;
  int   m_y;
  int   m_cix;
  int   m_ciy;
  int   tiles_done;
  logic m_loaded;

  logic [31:0] lfsr_state = 32'hf9504868;

  conv_load_input_ctrl dut_i (
    .clk, .reset, .conv_load_input, .req_ready,
    .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready,
    .req_valid, .req, .chunk_done
  );

  always #20 clk = ~clk;

  initial
  begin
    #(WATCHDOG_NS);
    $display("** FAIL **");
    $fatal(1, "watchdog expired, the tests did not finish in time");
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr stepped once per bit
  function automatic logic next_random_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    return out;
  endfunction

  // a start of 1 is first even when the tile runs past the layer edge
  function automatic int pos_class(input int start, input int step, input int limit);
    if (start == 1)
      return int'(CLASS_FIRST);
    else if (start + step - 1 > limit)
      return int'(CLASS_LAST);
    else
      return int'(CLASS_MID);
  endfunction

  function automatic logic [APB_DATA_W-1:0] pack_table(input int t0, input int t1, input int t2);
    return {8'h00, 8'(t2), 8'(t1), 8'(t0)};
  endfunction

  // one ddr request from the tile position and word indices
  function automatic ddr_req_t expected_req(input int cix, input int ciy, input int ifi);
    int       ix_start;
    int       iy_start;
    int       row;
    int       col;
    ddr_req_t r;
    ix_start  = (m_x - 1) * L_S + 1;
    iy_start  = (m_y - 1) * L_S + 1;
    row       = iy_start + ciy - 1 - L_P;
    col       = (cix - 1) * PIXELS_IN_ROW + ix_start;
    r.row_idx = 16'(row);
    r.if_idx  = 16'(ifi);
    r.pad     = (row < 1) || (row > L_IY);
    if (r.pad)
      r.adr = 16'(L_BASE);
    else
      r.adr = 16'(L_BASE + (row - 1) * (L_IX * L_NIF / 64) + (col - 1) * L_NIF / 64
                  + (ifi - 1) / 2);
    return r;
  endfunction

  task automatic model_reset();
    m_f        = 1;
    m_x        = 1;
    m_y        = 1;
    m_cix      = 1;
    m_ciy      = 1;
    tiles_done = 0;
    m_loaded   = 1'b0;
    exp_q.delete();
    got_q.delete();
  endtask

  // one compute term pulse fills exp_q with the burst it should start
  task automatic model_pulse(output logic start);
    logic f_wraps;
    logic done;
    int   ixs;
    int   iys;
    int   spl;
    int   words;
    f_wraps = (m_f + ROW_NUM_MODE0 > L_OF);
    start   = !m_loaded || f_wraps;
    if (f_wraps)
      m_loaded = 1'b0;
    m_f = f_wraps ? 1 : m_f + ROW_NUM_MODE0;
    if (start)
    begin
      ixs   = ix_words_tab[pos_class(m_x, PIXELS_IN_ROW, L_OX)];
      iys   = iy_rows_tab[pos_class(m_y, BUFFERS_NUM, L_OY)];
      spl   = split_tab[pos_class(m_y, BUFFERS_NUM, L_OY)][pos_class(m_x, PIXELS_IN_ROW, L_OX)];
      words = 0;
      done  = 1'b0;
      while (!done)
      begin
        // channel pairs fastest
        for (int i = 1; i <= L_NIF; i += 2)
          exp_q.push_back(expected_req(m_cix, m_ciy, i));
        words++;
        if (m_cix == ixs && m_ciy == iys)
        begin
          // last word of the tile moves on to the next spatial tile
          m_cix    = 1;
          m_ciy    = 1;
          m_loaded = 1'b1;
          tiles_done++;
          done = 1'b1;
          if (m_x + PIXELS_IN_ROW > L_OX)
          begin
            m_x = 1;
            m_y = (m_y + BUFFERS_NUM > L_OY) ? 1 : m_y + BUFFERS_NUM;
          end
          else
            m_x = m_x + PIXELS_IN_ROW;
        end
        else
        begin
          if (m_cix == ixs)
          begin
            m_cix = 1;
            m_ciy++;
          end
          else
            m_cix++;
          done = (words == spl);
        end
      end
    end
  endtask

  ////////////////////
  // checks
  ////////////////////

  task automatic raise_failure(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      raise_failure($sformatf("Fail %0t %s got %b expected %b", $time, name, got, exp));
  endtask

  task automatic check_data(input string name, input logic [APB_DATA_W-1:0] got,
                            input logic [APB_DATA_W-1:0] exp);
    if (got !== exp)
      raise_failure($sformatf("Fail %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  task automatic check_req(input string name, input ddr_req_t got, input ddr_req_t exp);
    if (got !== exp)
      raise_failure($sformatf(
        "Fail %0t %s got adr %h row %h if %h pad %b expected adr %h row %h if %h pad %b",
        $time, name, got.adr, got.row_idx, got.if_idx, got.pad,
        exp.adr, exp.row_idx, exp.if_idx, exp.pad));
  endtask

  ////////////////////
  // bus and pulse drivers
  ////////////////////

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;
    model_reset();
  endtask

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [APB_DATA_W-1:0] data);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [APB_DATA_W-1:0] data);
    next_cycle();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    check_bit("pready", pready, 1'b1);
    data = prdata;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // write the whole register map and read every register back
  task automatic configure_layer();
    logic [APB_ADDR_W-1:0] addrs [10];
    logic [APB_DATA_W-1:0] vals [10];
    logic [APB_DATA_W-1:0] rd;
    addrs = '{REG_DIMS, REG_OUT, REG_IN, REG_SHAPE, REG_BASE, REG_IX_WORDS,
              REG_IY_ROWS, REG_SPLIT_FIRST, REG_SPLIT_MID, REG_SPLIT_LAST};
    vals[0] = {16'(L_NIF), 16'(L_OF)};
    vals[1] = {16'(L_OY), 16'(L_OX)};
    vals[2] = {16'(L_IY), 16'(L_IX)};
    // mode 0 takes 64 output channels per term
    vals[3] = {8'h00, 4'(L_IX_LOG2), 4'(L_NIF_LOG2), 7'h00, 1'b0, 4'(L_P), 4'(L_S)};
    vals[4] = 32'(L_BASE);
    vals[5] = pack_table(ix_words_tab[0], ix_words_tab[1], ix_words_tab[2]);
    vals[6] = pack_table(iy_rows_tab[0], iy_rows_tab[1], iy_rows_tab[2]);
    for (int i = 0; i < 3; i++)
      vals[7 + i] = pack_table(split_tab[i][0], split_tab[i][1], split_tab[i][2]);
    for (int i = 0; i < 10; i++)
      apb_write(addrs[i], vals[i]);
    for (int i = 0; i < 10; i++)
    begin
      apb_read(addrs[i], rd);
      check_data($sformatf("prdata at %h", addrs[i]), rd, vals[i]);
    end
  endtask

  // one pulse on conv_load_input and the burst that follows word by word
  task automatic run_pulse(input logic random_ready, output logic started);
    logic     held;
    ddr_req_t held_req;
    ddr_req_t exp;
    model_pulse(started);
    next_cycle();
    conv_load_input = 1'b1;
    next_cycle();
    conv_load_input = 1'b0;
    check_bit("req_valid", req_valid, started);
    check_bit("chunk_done", chunk_done, 1'b0);
    if (started)
    begin
      held = 1'b0;
      while (exp_q.size() > 0)
      begin
        req_ready = random_ready ? next_random_bit() : 1'b1;
        if (!req_valid)
          raise_failure("req_valid dropped before the burst had sent all its words");
        // a stalled request must not change
        if (held)
          check_req("req", req, held_req);
        check_bit("chunk_done", chunk_done, 1'b0);
        if (req_ready)
        begin
          exp = exp_q.pop_front();
          check_req("req", req, exp);
          got_q.push_back(req);
          held = 1'b0;
        end
        else
        begin
          held     = 1'b1;
          held_req = req;
        end
        next_cycle();
      end
      // one cycle of chunk_done after the burst
      check_bit("req_valid", req_valid, 1'b0);
      check_bit("chunk_done", chunk_done, 1'b1);
      next_cycle();
      check_bit("chunk_done", chunk_done, 1'b0);
    end
    else
    begin
      next_cycle();
      check_bit("req_valid", req_valid, 1'b0);
    end
  endtask

  task automatic run_layer(input logic random_ready);
    logic started;
    while (tiles_done < TILES)
      run_pulse(random_ready, started);
    if (got_q.size() != LAYER_REQS)
      raise_failure("the layer did not produce the expected number of requests");
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic test_reset_regs();
    apply_reset();
    check_bit("req_valid", req_valid, 1'b0);
    check_bit("chunk_done", chunk_done, 1'b0);
    check_bit("pready", pready, 1'b1);
    configure_layer();
  endtask

  // also covers burst lengths and chunk_done placement
  task automatic test_layer_ready();
    req_ready = 1'b1;
    run_layer(1'b0);
  endtask

  task automatic test_idle_and_wrap();
    logic started;
    // tile loaded and channel loop not wrapping
    run_pulse(1'b0, started);
    check_bit("burst on a loaded tile", started, 1'b0);
    // wrapping pulse loads the next tile
    run_pulse(1'b0, started);
    check_bit("burst on a wrapping pulse", started, 1'b1);
  endtask

  // the same request sequence under back-pressure
  task automatic test_layer_random();
    apply_reset();
    configure_layer();
    run_layer(1'b1);
  endtask

  initial
  begin
    clk             = 1'b0;
    reset           = 1'b1;
    conv_load_input = 1'b0;
    req_ready       = 1'b0;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = '0;
    pwdata          = '0;
    test_reset_regs();
    test_layer_ready();
    test_idle_and_wrap();
    test_layer_random();
    $display("** PASS **");
    $finish;
  end

endmodule

// File: verilog.f
hdl/conv_load_pkg.sv
hdl/conv_load_regs.sv
hdl/conv_tile_sequencer.sv
hdl/conv_word_counter.sv
hdl/conv_ddr_addr_gen.sv
hdl/conv_load_input_ctrl.sv
verif/tb_conv_load.sv
